// ==== hw/vldu_pkg.sv ====
package vldu_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  // Bytes per lane word, set by the 64-bit element width
  localparam int unsigned LaneBytes = 8;
  // Bytes per memory read beat
  localparam int unsigned BeatBytes = 8;
  // Number of distinct instruction ids
  localparam int unsigned NrVInsn = 8;
  // Register file words per vector register in each lane
  localparam int unsigned RegWords = 32;

  //////////////////////////////
  // Scalar types
  //////////////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [4:0] vreg_t;
  typedef logic [15:0] vlen_t;
  typedef logic [15:0] vaddr_t;
  typedef logic [8*LaneBytes-1:0] elen_t;
  typedef logic [LaneBytes-1:0] strb_t;

  // Element width, also the byte shift of vl
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_t;

  //////////////////////////////
  // Interface structs
  //////////////////////////////

  // Load instruction from the sequencer
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vlen_t vl;
    sew_t  sew;
  } pe_req_t;

  // Burst descriptor, beats minus one
  typedef struct packed {
    logic [7:0] len;
  } addrgen_req_t;

  // One full, aligned read beat
  typedef struct packed {
    logic [8*BeatBytes-1:0] data;
  } r_beat_t;

  // Write request towards one lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } payload_t;

endpackage

// ==== hw/vldu_insn_queue.sv ====
`timescale 1ns/1ns

module vldu_insn_queue #(
  parameter int unsigned NrLanes        = 2,
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Sequencer side
  input  vldu_pkg::pe_req_t pe_req_i,
  input  logic              pe_req_valid_i,
  output logic              pe_req_ready_o,
  // Towards the packer
  output vldu_pkg::pe_req_t issue_insn_o,
  output logic              issue_valid_o,
  input  logic              issue_done_i,
  // From the result queue
  input  logic              word_retired_i,
  // Completion report
  output logic              load_complete_o,
  output vldu_pkg::vid_t    done_id_o
);

  import vldu_pkg::*;

  localparam int unsigned PtrW      = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW      = $clog2(InsnQueueDepth + 1);
  // Bytes retired per result word, all lanes together
  localparam vlen_t       WordBytes = vlen_t'(NrLanes * LaneBytes);

  // Pointers for the three phases, plus occupancy per phase
  typedef struct packed {
    logic [PtrW-1:0] accept_pnt;
    logic [PtrW-1:0] issue_pnt;
    logic [PtrW-1:0] commit_pnt;
    logic [CntW-1:0] issue_cnt;
    logic [CntW-1:0] commit_cnt;
  } queue_state_t;

  pe_req_t      insn_q [InsnQueueDepth];
  queue_state_t state_d, state_q;
  vlen_t        commit_bytes_d, commit_bytes_q;
  logic         accept;
  logic         commit_valid;

  // Wrap at the queue depth, which need not be a power of two
  function automatic logic [PtrW-1:0] next_pnt(input logic [PtrW-1:0] pnt);
    return (pnt == PtrW'(InsnQueueDepth - 1)) ? '0 : pnt + PtrW'(1);
  endfunction

  // Full when every slot still waits for its commit
  assign pe_req_ready_o = (state_q.commit_cnt != CntW'(InsnQueueDepth));
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  assign issue_insn_o  = insn_q[state_q.issue_pnt];
  assign issue_valid_o = (state_q.issue_cnt != '0);

  assign commit_valid = (state_q.commit_cnt != '0);
  assign done_id_o    = insn_q[state_q.commit_pnt].id;

  //////////////////////////////
  // Phase bookkeeping
  //////////////////////////////

  always_comb begin
    state_d         = state_q;
    commit_bytes_d  = commit_bytes_q;
    load_complete_o = 1'b0;

    // Packer placed the last byte of the issuing instruction
    if (issue_done_i) begin
      state_d.issue_pnt = next_pnt(state_q.issue_pnt);
      state_d.issue_cnt = state_q.issue_cnt - CntW'(1);
    end

    // One word left the result queue, floor at zero
    if (word_retired_i) begin
      if (commit_bytes_q > WordBytes)
        commit_bytes_d = commit_bytes_q - WordBytes;
      else
        commit_bytes_d = '0;
    end

    // All bytes of the commit instruction are in the lanes
    if (commit_valid && commit_bytes_d == '0) begin
      load_complete_o    = 1'b1;
      state_d.commit_pnt = next_pnt(state_q.commit_pnt);
      state_d.commit_cnt = state_q.commit_cnt - CntW'(1);
      // Next in line takes over the byte counter
      if (state_d.commit_cnt != '0)
        commit_bytes_d = insn_q[state_d.commit_pnt].vl << insn_q[state_d.commit_pnt].sew;
    end

    // New instruction, counter loads directly if nothing else commits
    if (accept) begin
      if (state_d.commit_cnt == '0)
        commit_bytes_d = pe_req_i.vl << pe_req_i.sew;
      state_d.accept_pnt = next_pnt(state_q.accept_pnt);
      state_d.issue_cnt  = state_d.issue_cnt + CntW'(1);
      state_d.commit_cnt = state_d.commit_cnt + CntW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= '0;
      commit_bytes_q <= '0;
    end else begin
      state_q        <= state_d;
      commit_bytes_q <= commit_bytes_d;
    end
  end

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept)
      insn_q[state_q.accept_pnt] <= pe_req_i;
  end

endmodule

// ==== hw/vldu_beat_packer.sv ====
`timescale 1ns/1ns

module vldu_beat_packer #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Issuing instruction
  input  vldu_pkg::pe_req_t                    issue_insn_i,
  input  logic                                 issue_valid_i,
  output logic                                 issue_done_o,
  // Burst descriptor
  input  vldu_pkg::addrgen_req_t               addrgen_req_i,
  input  logic                                 addrgen_valid_i,
  output logic                                 addrgen_ready_o,
  // Read channel
  input  vldu_pkg::r_beat_t                    r_beat_i,
  input  logic                                 r_valid_i,
  output logic                                 r_ready_o,
  // Towards the result queue
  output vldu_pkg::payload_t [NrLanes-1:0]     push_payload_o,
  output logic                                 push_valid_o,
  input  logic                                 push_ready_i
);

  import vldu_pkg::*;

  localparam int unsigned WordBytes = NrLanes * LaneBytes;
  localparam int unsigned BPntW     = $clog2(BeatBytes + 1);
  localparam int unsigned WPntW     = $clog2(WordBytes + 1);
  localparam int unsigned BIdxW     = $clog2(BeatBytes);

  // Bytes of the instruction already placed
  vlen_t                          issued_d, issued_q;
  // Next unread byte in the beat, next free byte in the word
  logic [BPntW-1:0]               beat_pnt_d, beat_pnt_q;
  logic [WPntW-1:0]               word_pnt_d, word_pnt_q;
  // Beats consumed in the current burst
  logic [7:0]                     beat_cnt_d, beat_cnt_q;
  // Word under construction, and the same word with this cycle's bytes merged
  logic [WordBytes-1:0][7:0]      word_data_q, word_data_m;
  logic [WordBytes-1:0]           word_be_q, word_be_m;

  logic [BeatBytes-1:0][7:0]      beat_bytes;
  vlen_t                          total_bytes, insn_left, beat_left, word_left, n_bytes;
  vlen_t                          src;
  vaddr_t                         word_addr;
  logic                           work;

  assign beat_bytes  = r_beat_i.data;
  assign total_bytes = issue_insn_i.vl << issue_insn_i.sew;

  // Room left in each of the three limits
  assign insn_left = total_bytes - issued_q;
  assign beat_left = vlen_t'(BeatBytes) - vlen_t'(beat_pnt_q);
  assign word_left = vlen_t'(WordBytes) - vlen_t'(word_pnt_q);

  always_comb begin
    n_bytes = (insn_left < word_left) ? insn_left : word_left;
    if (beat_left < n_bytes)
      n_bytes = beat_left;
  end

  // Beat, burst, instruction and a free result slot all present
  assign work = issue_valid_i && r_valid_i && addrgen_valid_i && push_ready_i;

  // Register word index within the instruction, vd selects the base
  assign word_addr = vaddr_t'(issue_insn_i.vd) * vaddr_t'(RegWords)
                   + vaddr_t'(issued_q / vlen_t'(WordBytes));

  //////////////////////////////
  // Byte placement
  //////////////////////////////

  always_comb begin
    issued_d        = issued_q;
    beat_pnt_d      = beat_pnt_q;
    word_pnt_d      = word_pnt_q;
    beat_cnt_d      = beat_cnt_q;
    word_data_m     = word_data_q;
    word_be_m       = word_be_q;
    src             = '0;
    r_ready_o       = 1'b0;
    addrgen_ready_o = 1'b0;
    issue_done_o    = 1'b0;
    push_valid_o    = 1'b0;

    if (issue_valid_i && total_bytes == '0) begin
      // Nothing to load, retire straight away
      issue_done_o = 1'b1;
    end else if (work) begin
      // Copy the window of n_bytes from beat into word
      for (int w = 0; w < WordBytes; w++) begin
        if (vlen_t'(w) >= vlen_t'(word_pnt_q) && vlen_t'(w) < vlen_t'(word_pnt_q) + n_bytes) begin
          src            = vlen_t'(beat_pnt_q) + vlen_t'(w) - vlen_t'(word_pnt_q);
          word_data_m[w] = beat_bytes[src[BIdxW-1:0]];
          word_be_m[w]   = 1'b1;
        end
      end
      issued_d   = issued_q + n_bytes;
      beat_pnt_d = beat_pnt_q + BPntW'(n_bytes);
      word_pnt_d = word_pnt_q + WPntW'(n_bytes);

      // Word full or instruction exhausted
      if (n_bytes == word_left || n_bytes == insn_left) begin
        push_valid_o = 1'b1;
        word_pnt_d   = '0;
      end

      // Beat drained, rest of a beat is dropped at the end of an instruction
      if (n_bytes == beat_left || n_bytes == insn_left) begin
        r_ready_o  = 1'b1;
        beat_pnt_d = '0;
        if (beat_cnt_q == addrgen_req_i.len) begin
          addrgen_ready_o = 1'b1;
          beat_cnt_d      = '0;
        end else begin
          beat_cnt_d = beat_cnt_q + 8'd1;
        end
      end

      if (n_bytes == insn_left) begin
        issue_done_o = 1'b1;
        issued_d     = '0;
      end
    end
  end

  // Lane l takes word bytes l*8 up to l*8+7
  always_comb begin
    for (int l = 0; l < NrLanes; l++) begin
      push_payload_o[l].id    = issue_insn_i.id;
      push_payload_o[l].addr  = word_addr;
      push_payload_o[l].wdata = word_data_m[l*LaneBytes +: LaneBytes];
      push_payload_o[l].be    = word_be_m[l*LaneBytes +: LaneBytes];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q    <= '0;
      beat_pnt_q  <= '0;
      word_pnt_q  <= '0;
      beat_cnt_q  <= '0;
      word_data_q <= '0;
      word_be_q   <= '0;
    end else begin
      issued_q   <= issued_d;
      beat_pnt_q <= beat_pnt_d;
      word_pnt_q <= word_pnt_d;
      beat_cnt_q <= beat_cnt_d;
      // Start from an empty word once the last one went out
      if (push_valid_o) begin
        word_data_q <= '0;
        word_be_q   <= '0;
      end else begin
        word_data_q <= word_data_m;
        word_be_q   <= word_be_m;
      end
    end
  end

endmodule

// ==== hw/vldu_result_queue.sv ====
`timescale 1ns/1ns

module vldu_result_queue #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // From the packer
  input  vldu_pkg::payload_t [NrLanes-1:0] push_payload_i,
  input  logic                             push_valid_i,
  output logic                             push_ready_o,
  // Lane write ports
  output logic               [NrLanes-1:0] ldu_result_req_o,
  output vldu_pkg::payload_t [NrLanes-1:0] ldu_result_o,
  input  logic               [NrLanes-1:0] ldu_result_gnt_i,
  // Head word fully granted
  output logic                             word_retired_o
);

  import vldu_pkg::*;

  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned PtrW             = $clog2(ResultQueueDepth);
  localparam int unsigned CntW             = $clog2(ResultQueueDepth + 1);

  // Slot storage and per-lane pending bits
  payload_t [ResultQueueDepth-1:0][NrLanes-1:0] slot_q;
  logic     [ResultQueueDepth-1:0][NrLanes-1:0] pend_d, pend_q;
  logic     [PtrW-1:0]                          wr_pnt_d, wr_pnt_q;
  logic     [PtrW-1:0]                          rd_pnt_d, rd_pnt_q;
  logic     [CntW-1:0]                          cnt_d, cnt_q;

  logic                                         push;
  logic     [NrLanes-1:0]                       head_left;

  assign push_ready_o = (cnt_q != CntW'(ResultQueueDepth));
  assign push         = push_valid_i && push_ready_o;

  // Head slot faces the lanes
  assign ldu_result_req_o = pend_q[rd_pnt_q];
  assign ldu_result_o     = slot_q[rd_pnt_q];

  // Lanes still owing a grant after this cycle
  assign head_left      = pend_q[rd_pnt_q] & ~ldu_result_gnt_i;
  assign word_retired_o = (cnt_q != '0) && (pend_q[rd_pnt_q] != '0) && (head_left == '0);

  //////////////////////////////
  // Pointer and pending update
  //////////////////////////////

  always_comb begin
    pend_d   = pend_q;
    wr_pnt_d = wr_pnt_q;
    rd_pnt_d = rd_pnt_q;
    cnt_d    = cnt_q;

    // Granted lanes drop their request
    pend_d[rd_pnt_q] = head_left;

    if (word_retired_o) begin
      rd_pnt_d = rd_pnt_q + PtrW'(1);
      cnt_d    = cnt_d - CntW'(1);
    end

    // New word requests every lane at once
    if (push) begin
      pend_d[wr_pnt_q] = '1;
      wr_pnt_d         = wr_pnt_q + PtrW'(1);
      cnt_d            = cnt_d + CntW'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      pend_q   <= pend_d;
      wr_pnt_q <= wr_pnt_d;
      rd_pnt_q <= rd_pnt_d;
      cnt_q    <= cnt_d;
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (push)
      slot_q[wr_pnt_q] <= push_payload_i;
  end

endmodule

// ==== hw/vldu_top.sv ====
`timescale 1ns/1ns

module vldu_top #(
  parameter int unsigned NrLanes        = 2,
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Sequencer
  input  vldu_pkg::pe_req_t                pe_req_i,
  input  logic                             pe_req_valid_i,
  output logic                             pe_req_ready_o,
  // Address generator
  input  vldu_pkg::addrgen_req_t           addrgen_req_i,
  input  logic                             addrgen_valid_i,
  output logic                             addrgen_ready_o,
  // Memory read channel
  input  vldu_pkg::r_beat_t                r_beat_i,
  input  logic                             r_valid_i,
  output logic                             r_ready_o,
  // Lanes
  output logic               [NrLanes-1:0] ldu_result_req_o,
  output vldu_pkg::payload_t [NrLanes-1:0] ldu_result_o,
  input  logic               [NrLanes-1:0] ldu_result_gnt_i,
  // Completion
  output logic                             load_complete_o,
  output vldu_pkg::vid_t                   done_id_o
);

  import vldu_pkg::*;

  // Queue to packer
  pe_req_t                issue_insn;
  logic                   issue_valid;
  logic                   issue_done;
  // Packer to result queue
  payload_t [NrLanes-1:0] push_payload;
  logic                   push_valid;
  logic                   push_ready;
  // Result queue back to the commit counter
  logic                   word_retired;

  vldu_insn_queue #(
    .NrLanes        (NrLanes),
    .InsnQueueDepth (InsnQueueDepth)
  ) insn_queue_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .issue_insn_o    (issue_insn),
    .issue_valid_o   (issue_valid),
    .issue_done_i    (issue_done),
    .word_retired_i  (word_retired),
    .load_complete_o (load_complete_o),
    .done_id_o       (done_id_o)
  );

  vldu_beat_packer #(
    .NrLanes (NrLanes)
  ) beat_packer_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_insn_i    (issue_insn),
    .issue_valid_i   (issue_valid),
    .issue_done_o    (issue_done),
    .addrgen_req_i   (addrgen_req_i),
    .addrgen_valid_i (addrgen_valid_i),
    .addrgen_ready_o (addrgen_ready_o),
    .r_beat_i        (r_beat_i),
    .r_valid_i       (r_valid_i),
    .r_ready_o       (r_ready_o),
    .push_payload_o  (push_payload),
    .push_valid_o    (push_valid),
    .push_ready_i    (push_ready)
  );

  vldu_result_queue #(
    .NrLanes (NrLanes)
  ) result_queue_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .push_payload_i   (push_payload),
    .push_valid_i     (push_valid),
    .push_ready_o     (push_ready),
    .ldu_result_req_o (ldu_result_req_o),
    .ldu_result_o     (ldu_result_o),
    .ldu_result_gnt_i (ldu_result_gnt_i),
    .word_retired_o   (word_retired)
  );

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset held low for a fixed number of cycles, released away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== testbench/tb_vldu.sv ====
`timescale 1ns/1ns

module tb_vldu;

  import vldu_pkg::*;

  localparam int unsigned NrLanes        = 2;
  localparam int unsigned InsnQueueDepth = 4;
  localparam int unsigned WordBytes      = NrLanes * LaneBytes;
  localparam int unsigned Timeout        = 2000;
  localparam int unsigned DrainTimeout   = 6000;

  logic                   clk;
  logic                   rst_n;
  pe_req_t                pe_req;
  logic                   pe_req_valid;
  logic                   pe_req_ready;
  addrgen_req_t           addrgen_req   = '0;
  logic                   addrgen_valid = 1'b0;
  logic                   addrgen_ready;
  r_beat_t                r_beat        = '0;
  logic                   r_valid       = 1'b0;
  logic                   r_ready;
  logic     [NrLanes-1:0] res_req;
  payload_t [NrLanes-1:0] res;
  logic     [NrLanes-1:0] res_gnt       = '0;
  logic                   load_complete;
  vid_t                   done_id;

  int seed = 60774;
  int err_cnt, final_err, timeout_cnt;
  int accept_cnt, complete_cnt, write_cnt, burst_cnt;

  // Reference model state, owned by the scoreboard
  payload_t           exp_q [NrLanes][$];
  payload_t           exp_head [NrLanes];
  logic [NrLanes-1:0] exp_have  = '0;
  vid_t               done_q [$];
  int                 grants_q [$];
  vid_t               head_id;
  int                 head_grants;
  logic               done_have = 1'b0;
  pe_req_t            acc_list [$];
  int                 outstanding, beats_taken;
  int unsigned        mem_addr, ref_addr;
  logic               rq_full_seen = 1'b0;
  logic               iq_full_seen = 1'b0;
  // Memory model burst state
  logic               mem_active = 1'b0;
  int                 next_burst, burst_beats, burst_end;
  // Lane stall control
  logic               stall_mode = 1'b0;
  int                 stall_left;

  tb_clk_gen #(.PeriodNs(20), .ResetCycles(5)) clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  vldu_top #(
    .NrLanes        (NrLanes),
    .InsnQueueDepth (InsnQueueDepth)
  ) dut_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .pe_req_i         (pe_req),
    .pe_req_valid_i   (pe_req_valid),
    .pe_req_ready_o   (pe_req_ready),
    .addrgen_req_i    (addrgen_req),
    .addrgen_valid_i  (addrgen_valid),
    .addrgen_ready_o  (addrgen_ready),
    .r_beat_i         (r_beat),
    .r_valid_i        (r_valid),
    .r_ready_o        (r_ready),
    .ldu_result_req_o (res_req),
    .ldu_result_o     (res),
    .ldu_result_gnt_i (res_gnt),
    .load_complete_o  (load_complete),
    .done_id_o        (done_id)
  );

  // Memory contents, scrambled over the full byte address
  function automatic logic [7:0] pattern_byte(input int unsigned a);
    logic [31:0] h;
    h = a * 32'h9E3779B1;
    return h[31:24] ^ h[15:8] ^ a[7:0];
  endfunction

  function automatic elen_t be_mask(input strb_t be);
    elen_t m;
    for (int i = 0; i < LaneBytes; i++)
      m[i*8 +: 8] = {8{be[i]}};
    return m;
  endfunction

  // Expected lane writes for one accepted load
  task automatic model_accept(input pe_req_t insn);
    int unsigned bytes, nwords, k;
    payload_t    p;
    bytes  = int'(insn.vl) << insn.sew;
    nwords = (bytes + WordBytes - 1) / WordBytes;
    for (int w = 0; w < nwords; w++) begin
      for (int l = 0; l < NrLanes; l++) begin
        p.id    = insn.id;
        p.addr  = vaddr_t'(insn.vd) * vaddr_t'(RegWords) + vaddr_t'(w);
        p.wdata = '0;
        p.be    = '0;
        for (int o = 0; o < LaneBytes; o++) begin
          k = w * WordBytes + l * LaneBytes + o;
          if (k < bytes) begin
            p.wdata[o*8 +: 8] = pattern_byte(ref_addr + k);
            p.be[o]           = 1'b1;
          end
        end
        exp_q[l].push_back(p);
      end
    end
    done_q.push_back(insn.id);
    grants_q.push_back(nwords * NrLanes);
    acc_list.push_back(insn);
    // Each burst covers whole beats, the tail of the last one is skipped
    ref_addr += ((bytes + BeatBytes - 1) / BeatBytes) * BeatBytes;
    outstanding++;
    accept_cnt++;
  endtask

  //////////////////////////////
  // Scoreboard
  //////////////////////////////

  always @(posedge clk) begin : scoreboard
    int n_grant;
    n_grant = 0;
    if (rst_n) begin
      for (int l = 0; l < NrLanes; l++) begin
        if (res_req[l] && res_gnt[l]) begin
          n_grant++;
          write_cnt++;
          if (exp_q[l].size() != 0)
            void'(exp_q[l].pop_front());
        end
      end
      if (grants_q.size() != 0)
        grants_q[0] -= n_grant;
      if (load_complete && done_q.size() != 0) begin
        void'(done_q.pop_front());
        void'(grants_q.pop_front());
        complete_cnt++;
        outstanding--;
      end
      // Read channel bookkeeping
      if (r_valid && r_ready) begin
        beats_taken++;
        mem_addr += BeatBytes;
      end
      if (addrgen_ready)
        burst_cnt++;
      if (!dut_i.push_ready)
        rq_full_seen = 1'b1;
      if (!pe_req_ready)
        iq_full_seen = 1'b1;
      if (pe_req_valid && pe_req_ready)
        model_accept(pe_req);
      // Heads seen by the assertions in the next cycle
      for (int l = 0; l < NrLanes; l++) begin
        exp_have[l] = (exp_q[l].size() != 0);
        exp_head[l] = exp_have[l] ? exp_q[l][0] : '0;
      end
      done_have   = (done_q.size() != 0);
      head_id     = done_have ? done_q[0] : '0;
      head_grants = done_have ? grants_q[0] : 0;
    end
  end

  //////////////////////////////
  // Memory and lane models
  //////////////////////////////

  // One burst per accepted load, in acceptance order, with random gaps
  // Random grants follow, long stalls in the second phase
  always @(negedge clk) begin : memory_lane_model
    logic [NrLanes-1:0] pick;
    if (mem_active && beats_taken == burst_end)
      mem_active = 1'b0;
    if (!mem_active && rst_n && next_burst < acc_list.size()) begin
      burst_beats = ((int'(acc_list[next_burst].vl) << acc_list[next_burst].sew)
                     + BeatBytes - 1) / BeatBytes;
      burst_end   = beats_taken + burst_beats;
      next_burst++;
      mem_active  = 1'b1;
    end
    addrgen_valid   = mem_active;
    addrgen_req.len = 8'(burst_beats - 1);
    r_valid         = mem_active && ($unsigned($random(seed)) % 4 != 0);
    for (int j = 0; j < BeatBytes; j++)
      r_beat.data[j*8 +: 8] = pattern_byte(mem_addr + j);

    // Lane grants
    pick = '0;
    if (stall_left > 0)
      stall_left--;
    else if (stall_mode && $unsigned($random(seed)) % 12 == 0)
      stall_left = 20 + $unsigned($random(seed)) % 40;
    else
      pick = NrLanes'($random(seed));
    res_gnt = rst_n ? (res_req & pick) : '0;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane_chk
    a_have: assert property (@(posedge clk) disable iff (!rst_n)
      res_req[l] && res_gnt[l] |-> exp_have[l])
      else begin
        err_cnt++;
        $display("Lane %0d wrote at %0t although no write was expected", l, $time);
      end
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
      res_req[l] && res_gnt[l] |-> (res[l].wdata & be_mask(exp_head[l].be)) == exp_head[l].wdata)
      else begin
        err_cnt++;
        $display("[ERROR] %0t ldu_result_o[%0d].wdata: got %h, expected %h", $time, l,
                 $sampled(res[l].wdata), $sampled(exp_head[l].wdata));
      end
    a_be: assert property (@(posedge clk) disable iff (!rst_n)
      res_req[l] && res_gnt[l] |-> res[l].be == exp_head[l].be)
      else begin
        err_cnt++;
        $display("[ERROR] %0t ldu_result_o[%0d].be: got %b, expected %b", $time, l,
                 $sampled(res[l].be), $sampled(exp_head[l].be));
      end
    a_addr: assert property (@(posedge clk) disable iff (!rst_n)
      res_req[l] && res_gnt[l] |-> res[l].addr == exp_head[l].addr)
      else begin
        err_cnt++;
        $display("[ERROR] %0t ldu_result_o[%0d].addr: got %0d, expected %0d", $time, l,
                 $sampled(res[l].addr), $sampled(exp_head[l].addr));
      end
    a_id: assert property (@(posedge clk) disable iff (!rst_n)
      res_req[l] && res_gnt[l] |-> res[l].id == exp_head[l].id)
      else begin
        err_cnt++;
        $display("[ERROR] %0t ldu_result_o[%0d].id: got %0d, expected %0d", $time, l,
                 $sampled(res[l].id), $sampled(exp_head[l].id));
      end
  end

  a_done_exp: assert property (@(posedge clk) disable iff (!rst_n) load_complete |-> done_have)
    else begin
      err_cnt++;
      $display("Completion at %0t with no load outstanding", $time);
    end
  a_done_id: assert property (@(posedge clk) disable iff (!rst_n)
    load_complete && done_have |-> done_id == head_id)
    else begin
      err_cnt++;
      $display("[ERROR] %0t done_id_o: got %0d, expected %0d", $time,
               $sampled(done_id), $sampled(head_id));
    end
  // Completion exactly on the final grant of the commit load
  a_done_time: assert property (@(posedge clk) disable iff (!rst_n)
    load_complete == (done_have && $countones(res_req & res_gnt) != 0
                      && head_grants == $countones(res_req & res_gnt)))
    else begin
      err_cnt++;
      $display("[ERROR] %0t load_complete_o: got %b, expected %b", $time,
               $sampled(load_complete), !$sampled(load_complete));
    end
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    pe_req_ready == (outstanding < int'(InsnQueueDepth)))
    else begin
      err_cnt++;
      $display("[ERROR] %0t pe_req_ready_o: got %b, expected %b", $time,
               $sampled(pe_req_ready), !$sampled(pe_req_ready));
    end
  a_rq_full: assert property (@(posedge clk) disable iff (!rst_n)
    !dut_i.push_ready |-> !r_ready)
    else begin
      err_cnt++;
      $display("Beat consumed at %0t while the result queue was full", $time);
    end
  a_r_valid: assert property (@(posedge clk) disable iff (!rst_n)
    r_ready |-> r_valid && mem_active)
    else begin
      err_cnt++;
      $display("Beat consumed at %0t with no beat offered", $time);
    end
  a_burst: assert property (@(posedge clk) disable iff (!rst_n)
    addrgen_ready == (mem_active && r_ready && beats_taken + 1 == burst_end))
    else begin
      err_cnt++;
      $display("[ERROR] %0t addrgen_ready_o: got %b, expected %b", $time,
               $sampled(addrgen_ready), !$sampled(addrgen_ready));
    end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  task automatic send_insn(input int idx, output logic ok);
    pe_req_t req;
    int      cycles;
    // Drawn ahead of the falling edge, where the models take their values
    req.id  = vid_t'(idx % NrVInsn);
    req.vd  = vreg_t'($unsigned($random(seed)) % 32);
    req.sew = sew_t'($unsigned($random(seed)) % 4);
    req.vl  = vlen_t'(1 + $unsigned($random(seed)) % 24);
    @(negedge clk);
    pe_req       = req;
    pe_req_valid = 1'b1;
    ok           = 1'b0;
    cycles       = 0;
    while (!ok && cycles < Timeout) begin
      @(posedge clk);
      ok = pe_req_ready;
      cycles++;
    end
    if (!ok) begin
      timeout_cnt++;
      $display("Load %0d was never accepted by the unit", idx);
    end
  endtask

  initial begin : main
    int   cycles;
    logic ok;
    pe_req       = '0;
    pe_req_valid = 1'b0;
    cycles       = 0;
    while (!rst_n && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    ok = rst_n;
    if (!ok) begin
      timeout_cnt++;
      $display("Reset was never released");
    end else begin
      assert (res_req == '0 && !r_ready && !addrgen_ready && !load_complete && pe_req_ready)
        else begin
          final_err++;
          $display("Outputs are not in their reset state after reset");
        end
    end
    // Free running grants first, then long grant stalls
    for (int i = 0; i < 40 && ok; i++) begin
      stall_mode = (i >= 24);
      send_insn(i, ok);
    end
    @(negedge clk);
    pe_req_valid = 1'b0;
    cycles = 0;
    while (ok && outstanding != 0 && cycles < DrainTimeout) begin
      @(posedge clk);
      cycles++;
    end
    if (ok && outstanding != 0) begin
      timeout_cnt++;
      $display("Loads still outstanding after the drain timeout");
    end
    // Let the assertions of the last edge settle
    @(negedge clk);
    assert (complete_cnt == accept_cnt && burst_cnt == accept_cnt && done_q.size() == 0)
      else begin
        final_err++;
        $display("Completions or bursts do not match the accepted loads");
      end
    for (int l = 0; l < NrLanes; l++) begin
      assert (exp_q[l].size() == 0)
        else begin
          final_err++;
          $display("Lane %0d is missing %0d writes", l, exp_q[l].size());
        end
    end
    assert (rq_full_seen && iq_full_seen)
      else begin
        final_err++;
        $display("Stimulus never filled the result queue or the instruction queue");
      end
    $display("Loads %0d, lane writes %0d, assertion errors %0d, final errors %0d, timeouts %0d",
             accept_cnt, write_cnt, err_cnt, final_err, timeout_cnt);
    if (err_cnt == 0 && final_err == 0 && timeout_cnt == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== build.f ====
hw/vldu_pkg.sv
hw/vldu_insn_queue.sv
hw/vldu_beat_packer.sv
hw/vldu_result_queue.sv
hw/vldu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_vldu.sv

// ==== Bender.yml ====
package:
  name: vldu

sources:
  - files:
      - hw/vldu_pkg.sv
      - hw/vldu_insn_queue.sv
      - hw/vldu_beat_packer.sv
      - hw/vldu_result_queue.sv
      - hw/vldu_top.sv

  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_vldu.sv
